// File: src/pipelinePkg.sv
package pipelinePkg;

    // word and result widths
    localparam int botWidth = 128;
    localparam int sumWidth = 38;
    localparam int countWidth = 3;
    localparam int pcoeffWidth = 8;             // holds 0..128

    // popcount lane split
    localparam int laneWidth = 32;
    localparam int numLanes = botWidth / laneWidth;
    localparam int laneCountWidth = 6;          // holds 0..32

    // result buffer sizing
    localparam int fifoDepth = 8;
    localparam int fifoAddrWidth = 3;
    localparam int fifoCountWidth = fifoAddrWidth + 1;

    // cycles from an accepted input to its FIFO write
    localparam int datapathLatency = 4;
    localparam int inFlightWidth = 3;           // holds 0..datapathLatency

    typedef logic [botWidth-1:0] botWord_t;
    typedef logic [sumWidth-1:0] sumValue_t;
    typedef logic [countWidth-1:0] pcoeffCount_t;
    typedef logic [pcoeffWidth-1:0] pcoeff_t;

endpackage

// File: src/controlPkg.sv
package controlPkg;

    // what the accumulator does with the item in its stage
    typedef enum logic [1:0] {
        ACC_NONE    = 2'd0,     // bubble
        ACC_RESTART = 2'd1,     // new top, clear sum and count
        ACC_ADD     = 2'd2      // bot, add coefficient and emit
    } accOp_t;

    // fill level of the result buffer
    typedef enum logic [1:0] {
        FILL_EMPTY   = 2'd0,
        FILL_PARTIAL = 2'd1,
        FILL_FULL    = 2'd2
    } fifoFill_t;

endpackage

// File: src/botIntake.sv
`timescale 1ns/1ns

module botIntake (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  inValid,
    input  logic                  startNewTop,
    input  pipelinePkg::botWord_t bot,
    input  logic                  inReady,
    output controlPkg::accOp_t    stage1Op,
    output pipelinePkg::botWord_t diffMask,
    output logic                  admissible
);
    import pipelinePkg::*;
    import controlPkg::*;

    botWord_t topWord;          // current top
    botWord_t topMinusBot;
    logic     accept;
    logic     botFits;

    assign accept = inValid && inReady;

    // a bot fits when none of its bits lie outside the top
    assign botFits = ((bot & ~topWord) == '0);
    assign topMinusBot = topWord & ~bot;

    always_ff @(posedge clock) begin
        if (!rst) begin
            stage1Op <= ACC_NONE;
            topWord <= '0;
        end else begin
            if (!accept) begin
                stage1Op <= ACC_NONE;
            end else if (startNewTop) begin
                stage1Op <= ACC_RESTART;
                topWord <= bot;             // word carries the new top
            end else begin
                stage1Op <= ACC_ADD;
            end
        end
    end

    // mask is forced to zero for an inadmissible bot so its coefficient is zero
    always_ff @(posedge clock) begin
        if (accept && !startNewTop) begin
            admissible <= botFits;
            diffMask <= botFits ? topMinusBot : '0;
        end else begin
            admissible <= 1'b0;
            diffMask <= '0;
        end
    end

endmodule

// File: src/pcoeffCounter.sv
`timescale 1ns/1ns

module pcoeffCounter (
    input  logic                  clock,
    input  logic                  rst,
    input  controlPkg::accOp_t    stage1Op,
    input  pipelinePkg::botWord_t diffMask,
    input  logic                  admissible,
    output controlPkg::accOp_t    stage3Op,
    output pipelinePkg::pcoeff_t  pcoeff,
    output logic                  admissibleOut
);
    import pipelinePkg::*;
    import controlPkg::*;

    accOp_t                    stage2Op;
    logic                      stage2Admissible;
    logic [laneCountWidth-1:0] laneCnt [numLanes];
    pcoeff_t                   laneTotal;

    function automatic logic [laneCountWidth-1:0] laneOnes(input logic [laneWidth-1:0] lane);
        logic [laneCountWidth-1:0] ones;
        ones = '0;
        for (int i = 0; i < laneWidth; i++) begin
            ones = ones + laneCountWidth'(lane[i]);
        end
        return ones;
    endfunction

    // stage 3 adder over the registered lane counts
    always_comb begin
        laneTotal = '0;
        for (int l = 0; l < numLanes; l++) begin
            laneTotal = laneTotal + pcoeff_t'(laneCnt[l]);
        end
    end

    always_ff @(posedge clock) begin
        if (!rst) begin
            stage2Op <= ACC_NONE;
            stage3Op <= ACC_NONE;
        end else begin
            stage2Op <= stage1Op;
            stage3Op <= stage2Op;
        end
    end

    always_ff @(posedge clock) begin
        for (int l = 0; l < numLanes; l++) begin
            laneCnt[l] <= laneOnes(diffMask[l*laneWidth +: laneWidth]);   // stage 2
        end
        stage2Admissible <= admissible;
        pcoeff <= laneTotal;                                            // stage 3
        admissibleOut <= stage2Admissible;
    end

endmodule

// File: src/pcoeffAccumulator.sv
`timescale 1ns/1ns

module pcoeffAccumulator (
    input  logic                      clock,
    input  logic                      rst,
    input  controlPkg::accOp_t        stage3Op,
    input  pipelinePkg::pcoeff_t      pcoeff,
    input  logic                      admissibleOut,
    output logic                      resultWrite,
    output pipelinePkg::sumValue_t    resultSum,
    output pipelinePkg::pcoeffCount_t resultCount
);
    import pipelinePkg::*;
    import controlPkg::*;

    sumValue_t    sumReg;       // running sum since the last top
    pcoeffCount_t countReg;     // admissible bots since the last top, mod 8

    // the registers already hold the updated pair when resultWrite is high
    assign resultSum = sumReg;
    assign resultCount = countReg;

    always_ff @(posedge clock) begin
        if (!rst) begin
            sumReg <= '0;
            countReg <= '0;
            resultWrite <= 1'b0;
        end else begin
            case (stage3Op)
                ACC_RESTART: begin
                    sumReg <= '0;
                    countReg <= '0;
                    resultWrite <= 1'b0;     // a top emits nothing
                end
                ACC_ADD: begin
                    sumReg <= sumReg + sumValue_t'(pcoeff);
                    countReg <= countReg + pcoeffCount_t'(admissibleOut);   // wraps
                    resultWrite <= 1'b1;
                end
                default: begin
                    resultWrite <= 1'b0;
                end
            endcase
        end
    end

endmodule

// File: src/resultFifo.sv
`timescale 1ns/1ns

module resultFifo (
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      acceptIn,
    input  logic                      resultWrite,
    input  pipelinePkg::sumValue_t    resultSum,
    input  pipelinePkg::pcoeffCount_t resultCount,
    output logic                      inReady,
    output logic                      outValid,
    output pipelinePkg::sumValue_t    summedData,
    output pipelinePkg::pcoeffCount_t pcoeffCount,
    input  logic                      outReady
);
    import pipelinePkg::*;
    import controlPkg::*;

    sumValue_t                 sumMem [fifoDepth];
    pcoeffCount_t              countMem [fifoDepth];
    logic [fifoAddrWidth-1:0]  wrPtr;
    logic [fifoAddrWidth-1:0]  rdPtr;
    logic [fifoCountWidth-1:0] fillCount;
    logic [inFlightWidth-1:0]  inFlight;       // accepted items not yet at the write point
    logic [datapathLatency-1:0] acceptPipe;    // tracks each accepted item down the datapath
    fifoFill_t                 fillState;
    logic                      doWrite;
    logic                      doRead;

    always_comb begin
        if (fillCount == '0) begin
            fillState = FILL_EMPTY;
        end else if (fillCount == fifoCountWidth'(fifoDepth)) begin
            fillState = FILL_FULL;
        end else begin
            fillState = FILL_PARTIAL;
        end
    end

    assign outValid = (fillState != FILL_EMPTY);
    assign doRead = outValid && outReady;
    assign doWrite = resultWrite && (fillState != FILL_FULL);

    // one more item may enter only if every item in flight still has a slot
    assign inReady = (int'(fillCount) + int'(inFlight) + 1) <= fifoDepth;

    assign summedData = sumMem[rdPtr];     // head entry
    assign pcoeffCount = countMem[rdPtr];

    always_ff @(posedge clock) begin
        if (!rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fillCount <= '0;
            inFlight <= '0;
            acceptPipe <= '0;
        end else begin
            acceptPipe <= {acceptPipe[datapathLatency-2:0], acceptIn};
            // last pipe bit marks the cycle the item is written, or dropped if it was a top
            inFlight <= inFlight + inFlightWidth'(acceptIn)
                        - inFlightWidth'(acceptPipe[datapathLatency-1]);
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10:   fillCount <= fillCount + 1'b1;
                2'b01:   fillCount <= fillCount - 1'b1;
                default: fillCount <= fillCount;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (doWrite) begin
            sumMem[wrPtr] <= resultSum;
            countMem[wrPtr] <= resultCount;
        end
    end

endmodule

// File: src/fullPipeline.sv
`timescale 1ns/1ns

module fullPipeline (
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      inValid,
    input  logic                      startNewTop,
    input  pipelinePkg::botWord_t     bot,
    output logic                      inReady,
    output logic                      outValid,
    output pipelinePkg::sumValue_t    summedData,
    output pipelinePkg::pcoeffCount_t pcoeffCount,
    input  logic                      outReady
);
    import pipelinePkg::*;
    import controlPkg::*;

    logic         acceptIn;
    accOp_t       stage1Op;
    botWord_t     diffMask;
    logic         admissible;
    accOp_t       stage3Op;
    pcoeff_t      pcoeff;
    logic         admissibleOut;
    logic         resultWrite;
    sumValue_t    resultSum;
    pcoeffCount_t resultCount;

    assign acceptIn = inValid && inReady;

    botIntake u_botIntake (
        .clock       (clock),
        .rst         (rst),
        .inValid     (inValid),
        .startNewTop (startNewTop),
        .bot         (bot),
        .inReady     (inReady),
        .stage1Op    (stage1Op),
        .diffMask    (diffMask),
        .admissible  (admissible)
    );

    pcoeffCounter u_pcoeffCounter (
        .clock         (clock),
        .rst           (rst),
        .stage1Op      (stage1Op),
        .diffMask      (diffMask),
        .admissible    (admissible),
        .stage3Op      (stage3Op),
        .pcoeff        (pcoeff),
        .admissibleOut (admissibleOut)
    );

    pcoeffAccumulator u_pcoeffAccumulator (
        .clock         (clock),
        .rst           (rst),
        .stage3Op      (stage3Op),
        .pcoeff        (pcoeff),
        .admissibleOut (admissibleOut),
        .resultWrite   (resultWrite),
        .resultSum     (resultSum),
        .resultCount   (resultCount)
    );

    resultFifo u_resultFifo (
        .clock       (clock),
        .rst         (rst),
        .acceptIn    (acceptIn),
        .resultWrite (resultWrite),
        .resultSum   (resultSum),
        .resultCount (resultCount),
        .inReady     (inReady),
        .outValid    (outValid),
        .summedData  (summedData),
        .pcoeffCount (pcoeffCount),
        .outReady    (outReady)
    );

endmodule

// File: verif/fullPipeline_assert.sv
`timescale 1ns/1ns

module fullPipeline_assert (
    input logic                      clock,
    input logic                      rst,
    input logic                      inReady,
    input logic                      outValid,
    input logic                      outReady,
    input pipelinePkg::sumValue_t    summedData,
    input pipelinePkg::pcoeffCount_t pcoeffCount,
    input controlPkg::fifoFill_t     fillState
);
    import controlPkg::*;

    // head entry holds until the consumer takes it
    property holdWhileStalled;
        @(posedge clock) disable iff (!rst)
            (outValid && !outReady) |=>
                (outValid && $stable(summedData) && $stable(pcoeffCount));
    endproperty

    property noReadyWhenFull;
        @(posedge clock) disable iff (!rst)
            (fillState == FILL_FULL) |-> !inReady;
    endproperty

    property idleAfterReset;
        @(posedge clock) !rst |=> !outValid;
    endproperty

    assert property (holdWhileStalled)
        else $error("output stream changed while outReady was low");
    assert property (noReadyWhenFull)
        else $error("inReady high while the result FIFO is full");
    assert property (idleAfterReset)
        else $error("outValid high in the cycle after reset");

endmodule

bind fullPipeline fullPipeline_assert u_assert (
    .clock       (clock),
    .rst         (rst),
    .inReady     (inReady),
    .outValid    (outValid),
    .outReady    (outReady),
    .summedData  (summedData),
    .pcoeffCount (pcoeffCount),
    .fillState   (u_resultFifo.fillState)
);

// File: verif/fullPipelineTb.sv
`timescale 1ns/1ns

module fullPipelineTb;
    import pipelinePkg::*;

    localparam int numVectors = 20;
    localparam int vecWidth = 176;          // flag, word, sum and count as hex fields
    localparam int clockHalf = 20;
    localparam int driveDelay = 2;
    localparam int acceptTimeout = 100;
    localparam int resultTimeout = 300;
    localparam int stallCycles = 60;        // heavy back-pressure window at the start
    localparam int drainCycles = 10;

    logic         clock;
    logic         rst;
    logic         inValid;
    logic         startNewTop;
    botWord_t     bot;
    logic         inReady;
    logic         outValid;
    sumValue_t    summedData;
    pcoeffCount_t pcoeffCount;
    logic         outReady;

    logic [vecWidth-1:0] vectors [numVectors];
    integer seed = 98;
    int sumErrors;
    int countErrors;
    int stateErrors;
    int timeoutErrors;
    int fileErrors;

    fullPipeline u_dut (
        .clock       (clock),
        .rst         (rst),
        .inValid     (inValid),
        .startNewTop (startNewTop),
        .bot         (bot),
        .inReady     (inReady),
        .outValid    (outValid),
        .summedData  (summedData),
        .pcoeffCount (pcoeffCount),
        .outReady    (outReady)
    );

    initial begin
        clock = 1'b0;
        forever #clockHalf clock = ~clock;
    end

    // consumer mostly stalls at first so the FIFO fills up, then mostly accepts
    initial begin
        int cycleNum;
        cycleNum = 0;
        outReady = 1'b0;
        forever begin
            @(posedge clock);
            #driveDelay;
            cycleNum++;
            if (cycleNum < stallCycles) begin
                outReady = (($random(seed) & 3) == 0);
            end else begin
                outReady = (($random(seed) & 3) != 0);
            end
        end
    end

    task automatic checkSum(input sumValue_t actual, input sumValue_t expected, input int index);
        if (actual !== expected) begin
            $display("** Error at %0t ns: result %0d has sum %0d, expected %0d",
                     $time, index, actual, expected);
            sumErrors++;
        end
    endtask

    task automatic checkCount(input pcoeffCount_t actual, input pcoeffCount_t expected,
                              input int index);
        if (actual !== expected) begin
            $display("** Error at %0t ns: result %0d has count %0d, expected %0d",
                     $time, index, actual, expected);
            countErrors++;
        end
    endtask

    // presents each word and holds it until the DUT takes it
    task automatic driveVectors();
        int waitCycles;
        for (int i = 0; i < numVectors; i++) begin
            inValid = 1'b1;
            startNewTop = vectors[i][172];
            bot = vectors[i][171:44];
            waitCycles = 0;
            @(negedge clock);
            while (!inReady && waitCycles < acceptTimeout) begin
                waitCycles++;
                @(negedge clock);
            end
            if (!inReady) begin
                $display("Timeout: input word %0d was never accepted by the DUT", i);
                timeoutErrors++;
                inValid = 1'b0;
                return;
            end
            @(posedge clock);       // transfer happens on this edge
            #driveDelay;
        end
        inValid = 1'b0;
        startNewTop = 1'b0;
        bot = '0;
    endtask

    // expects one result per bot line, in file order
    task automatic checkResults();
        int resultIndex;
        int waitCycles;
        resultIndex = 0;
        for (int i = 0; i < numVectors; i++) begin
            if (vectors[i][172]) begin
                continue;           // a top has no result
            end
            waitCycles = 0;
            @(negedge clock);
            while (!(outValid && outReady) && waitCycles < resultTimeout) begin
                waitCycles++;
                @(negedge clock);
            end
            if (!(outValid && outReady)) begin
                $display("Timeout: result %0d never came out of the DUT", resultIndex);
                timeoutErrors++;
                return;
            end
            checkSum(summedData, vectors[i][41:4], resultIndex);
            checkCount(pcoeffCount, vectors[i][2:0], resultIndex);
            resultIndex++;
        end
    endtask

    initial begin
        rst = 1'b0;
        inValid = 1'b0;
        startNewTop = 1'b0;
        bot = '0;
        sumErrors = 0;
        countErrors = 0;
        stateErrors = 0;
        timeoutErrors = 0;
        fileErrors = 0;
        $readmemh("verif/pipelineVectors.mem", vectors);
        for (int i = 0; i < numVectors; i++) begin
            if ($isunknown(vectors[i])) begin
                $display("Vector file has no valid entry for line %0d", i);
                fileErrors++;
            end
        end
        repeat (5) @(posedge clock);
        #driveDelay;
        rst = 1'b1;
        @(negedge clock);
        if (outValid !== 1'b0) begin
            $display("** Error at %0t ns: outValid is high right after reset", $time);
            stateErrors++;
        end
        if (inReady !== 1'b1) begin
            $display("** Error at %0t ns: inReady is low right after reset", $time);
            stateErrors++;
        end
        @(posedge clock);
        #driveDelay;
        fork
            driveVectors();
            checkResults();
        join
        // nothing may follow the last result
        repeat (drainCycles) begin
            @(negedge clock);
            if (outValid) begin
                $display("** Error at %0t ns: extra result %0d on the output",
                         $time, summedData);
                stateErrors++;
            end
        end
        $display("errors: sum %0d, count %0d, state %0d, timeout %0d, file %0d",
                 sumErrors, countErrors, stateErrors, timeoutErrors, fileErrors);
        if (sumErrors + countErrors + stateErrors + timeoutErrors + fileErrors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: verif/pipelineVectors.mem
// columns: startNewTop _ 128-bit word as four lanes, msb first _ expected sum _ expected count
// a line with startNewTop 1 loads a new top and has no result, its sum and count are zero
1_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_0000000000_0
0_00000000_00000000_00000000_00000000_0000000080_1
0_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_0000000080_2
0_0000000F_00000000_00000000_00000000_00000000FC_3
0_FFFFFFFF_00000000_FFFFFFFF_00000000_000000013C_4
0_00000000_00000000_00000000_000000FF_00000001B4_5
0_00000000_00000000_00000000_00000000_0000000234_6
0_00000000_00000000_00000000_00000000_00000002B4_7
0_00000000_00000000_00000000_00000000_0000000334_0
0_80000000_00000000_00000000_00000001_00000003B2_1
1_0000FFFF_00000000_00000000_F0F0F0F0_0000000000_0
0_0000000F_00000000_00000000_00000000_000000001C_1
0_00000000_00000000_00000000_0F0F0F0F_000000001C_1
0_00000000_00000000_00000000_F0F0F0F0_000000002C_2
0_00010000_00000000_00000000_00000000_000000002C_2
0_00000000_00000000_00000000_00000000_000000004C_3
1_00000000_00000000_00000001_00000000_0000000000_0
0_00000000_00000000_00000000_00000000_0000000001_1
0_00000000_00000000_00000001_00000000_0000000001_2
0_00000000_00000000_00000000_00000001_0000000001_2

// File: sources.f
src/pipelinePkg.sv
src/controlPkg.sv
src/botIntake.sv
src/pcoeffCounter.sv
src/pcoeffAccumulator.sv
src/resultFifo.sv
src/fullPipeline.sv
verif/fullPipeline_assert.sv
verif/fullPipelineTb.sv
